/* design/soc_pkg.sv */
//----------------------------------------------------------------------
// Shared definitions for the application subsystem:
// bus widths, area and core prefixes, register indices,
// request and response structs and the response source enum.
//----------------------------------------------------------------------
`default_nettype none

package soc_pkg;

  // Widths with a meaning
  localparam int RAM_ADDR_BITS = 8;
  localparam int NUM_CORES     = 4;
  localparam int CORE_SEL_BITS = $clog2(NUM_CORES);

  typedef logic [31 : 0]              word_t;
  typedef logic [31 : 0]              addr_t;
  typedef logic [3 : 0]               strb_t;
  typedef logic [1 : 0]               area_t;
  typedef logic [5 : 0]               core_prefix_t;
  typedef logic [7 : 0]               reg_addr_t;
  typedef logic [RAM_ADDR_BITS-1 : 0] ram_addr_t;
  typedef logic [CORE_SEL_BITS-1 : 0] core_sel_t;

  //--------------------------------------------------------------------
  // Memory map
  //--------------------------------------------------------------------
  localparam area_t        AREA_RAM        = 2'h1;
  localparam area_t        AREA_MMIO       = 2'h3;
  localparam core_prefix_t SYS_CTRL_PREFIX = 6'h3f;

  // Returned on a forced trap
  localparam word_t ILLEGAL_INSTRUCTION = 32'h0;

  // sys_ctrl registers
  localparam reg_addr_t SYS_APP_MODE = 8'h00;
  localparam reg_addr_t SYS_SCRAMBLE = 8'h01;
  localparam reg_addr_t SYS_ASLR     = 8'h02;

  // reg_core registers, scratch words sit below the counter
  localparam int        CORE_NUM_SCRATCH = 4;
  localparam reg_addr_t CORE_WR_COUNT    = 8'h04;

  //--------------------------------------------------------------------
  // Bus and target types
  //--------------------------------------------------------------------
  typedef struct packed {
    addr_t addr;
    word_t wdata;
    strb_t wstrb;
    logic  instr;
  } bus_req_t;

  typedef struct packed {
    logic      cs;
    logic      we;
    reg_addr_t address;
    word_t     write_data;
  } core_req_t;

  typedef struct packed {
    word_t read_data;
    logic  ready;
  } core_rsp_t;

  typedef enum logic [2 : 0] {NONE, RAM, SYS, CORE, TRAP} target_e;

endpackage

`default_nettype wire

/* design/mem_decoder.sv */
//----------------------------------------------------------------------
// Memory request decoder.
// Area and core prefix decode, chip selects for RAM, sys_ctrl
// and the MMIO cores, trap forcing in application mode, and
// the response source for the read-data mux.
//----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module mem_decoder (
  input  logic                clk,
  input  logic                reset_n,
  input  logic                bus_valid,
  input  soc_pkg::bus_req_t   bus_req,
  input  logic                bus_ready,
  input  logic                app_mode,
  output soc_pkg::core_req_t  sys_req,
  output logic                ram_cs,
  output soc_pkg::strb_t      ram_we,
  output soc_pkg::ram_addr_t  ram_addr,
  output soc_pkg::word_t      ram_wdata,
  output soc_pkg::core_req_t  core_req [soc_pkg::NUM_CORES],
  output soc_pkg::target_e    target,
  output soc_pkg::core_sel_t  core_sel
);

  soc_pkg::area_t        area;
  soc_pkg::core_prefix_t core_prefix;
  soc_pkg::core_req_t    mmio_req;

  assign area        = bus_req.addr[31 : 30];
  assign core_prefix = bus_req.addr[29 : 24];

  // Common MMIO request, only cs differs between cores
  assign mmio_req.cs         = 1'b0;
  assign mmio_req.we         = |bus_req.wstrb;
  assign mmio_req.address    = bus_req.addr[9 : 2];
  assign mmio_req.write_data = bus_req.wdata;

  assign ram_addr  = bus_req.addr[9 : 2];
  assign ram_wdata = bus_req.wdata;
  assign core_sel  = core_prefix[soc_pkg::CORE_SEL_BITS-1 : 0];

  always_comb begin
    sys_req = mmio_req;
    ram_cs  = 1'b0;
    ram_we  = '0;
    for (int i = 0; i < soc_pkg::NUM_CORES; i++) begin
      core_req[i] = mmio_req;
    end

    // Idle points at sys_ctrl with cs low, so the muxed ready stays low
    target = soc_pkg::SYS;

    if (bus_valid && !bus_ready) begin
      if (app_mode && bus_req.instr && area == soc_pkg::AREA_MMIO) begin
        target = soc_pkg::TRAP;
      end else begin
        case (area)
          soc_pkg::AREA_RAM: begin
            ram_cs = 1'b1;
            ram_we = bus_req.wstrb;
            target = soc_pkg::RAM;
          end
          soc_pkg::AREA_MMIO: begin
            if (core_prefix == soc_pkg::SYS_CTRL_PREFIX) begin
              sys_req.cs = 1'b1;
            end else if (core_prefix < soc_pkg::NUM_CORES) begin
              core_req[core_sel].cs = 1'b1;
              target = soc_pkg::CORE;
            end else begin
              target = soc_pkg::NONE;
            end
          end
          // Reserved areas answer with zero
          default: target = soc_pkg::NONE;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* design/sys_ctrl.sv */
//----------------------------------------------------------------------
// System control core.
// Sticky application-mode flag, RAM scramble key and ASLR mask.
// Key and mask are locked once application mode is entered.
//----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module sys_ctrl (
  input  logic               clk,
  input  logic               reset_n,
  input  soc_pkg::core_req_t req,
  output soc_pkg::core_rsp_t rsp,
  output logic               app_mode,
  output soc_pkg::word_t     scramble_key,
  output soc_pkg::word_t     aslr_mask
);

  //--------------------------------------------------------------------
  // Register update
  //--------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      app_mode     <= 1'b0;
      scramble_key <= '0;
      aslr_mask    <= '0;
    end else if (req.cs && req.we) begin
      case (req.address)
        // Any write enters application mode until reset
        soc_pkg::SYS_APP_MODE: app_mode <= 1'b1;
        soc_pkg::SYS_SCRAMBLE: begin
          if (!app_mode) begin
            scramble_key <= req.write_data;
          end
        end
        soc_pkg::SYS_ASLR: begin
          if (!app_mode) begin
            aslr_mask <= req.write_data;
          end
        end
        default: ;
      endcase
    end
  end

  //--------------------------------------------------------------------
  // Read back
  //--------------------------------------------------------------------
  always_comb begin
    rsp.ready = req.cs;
    case (req.address)
      soc_pkg::SYS_APP_MODE: rsp.read_data = {31'h0, app_mode};
      soc_pkg::SYS_SCRAMBLE: rsp.read_data = scramble_key;
      soc_pkg::SYS_ASLR:     rsp.read_data = aslr_mask;
      default:               rsp.read_data = '0;
    endcase
  end

endmodule

`default_nettype wire

/* design/scramble_ram.sv */
//----------------------------------------------------------------------
// Scrambled word RAM.
// Logical word index is remapped by the ASLR mask and each word
// is whitened with the scramble key and its byte address.
// Registered read, ready follows cs by one cycle.
//----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module scramble_ram (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               cs,
  input  soc_pkg::strb_t     we,
  input  soc_pkg::ram_addr_t addr,
  input  soc_pkg::word_t     wdata,
  input  logic [15 : 0]      byte_addr,
  input  soc_pkg::word_t     scramble_key,
  input  soc_pkg::word_t     aslr_mask,
  output soc_pkg::core_rsp_t rsp
);

  localparam int DEPTH = 1 << soc_pkg::RAM_ADDR_BITS;

  soc_pkg::word_t     mem [DEPTH];
  soc_pkg::ram_addr_t phys_addr;
  soc_pkg::word_t     whitening;
  soc_pkg::word_t     stored_word;
  soc_pkg::word_t     rdata_reg;
  logic               ready_reg;

  assign phys_addr   = addr ^ aslr_mask[soc_pkg::RAM_ADDR_BITS-1 : 0];
  assign whitening   = scramble_key ^ {2{byte_addr}};
  assign stored_word = wdata ^ whitening;

  // Storage and read path, descrambled on the way out
  always_ff @(posedge clk) begin
    if (cs) begin
      rdata_reg <= mem[phys_addr] ^ whitening;
    end
    if (cs && ready_reg) begin
      for (int i = 0; i < 4; i++) begin
        if (we[i]) begin
          mem[phys_addr][8*i +: 8] <= stored_word[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      ready_reg <= 1'b0;
    end else begin
      ready_reg <= cs;
    end
  end

  assign rsp.read_data = rdata_reg;
  assign rsp.ready     = ready_reg;

endmodule

`default_nettype wire

/* design/reg_core.sv */
//----------------------------------------------------------------------
// MMIO register core.
// Four scratch words and a counter of accepted scratch writes.
//----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module reg_core (
  input  logic               clk,
  input  logic               reset_n,
  input  soc_pkg::core_req_t req,
  output soc_pkg::core_rsp_t rsp
);

  soc_pkg::word_t scratch [soc_pkg::CORE_NUM_SCRATCH];
  soc_pkg::word_t wr_count;
  logic           scratch_hit;

  assign scratch_hit = req.address < soc_pkg::CORE_NUM_SCRATCH;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      for (int i = 0; i < soc_pkg::CORE_NUM_SCRATCH; i++) begin
        scratch[i] <= '0;
      end
      wr_count <= '0;
    end else if (req.cs && req.we) begin
      if (scratch_hit) begin
        scratch[req.address[1 : 0]] <= req.write_data;
        wr_count                    <= wr_count + 32'd1;
      end else if (req.address == soc_pkg::CORE_WR_COUNT) begin
        wr_count <= '0;
      end
    end
  end

  // Unmapped indices read as zero
  always_comb begin
    rsp.ready = req.cs;
    if (scratch_hit) begin
      rsp.read_data = scratch[req.address[1 : 0]];
    end else if (req.address == soc_pkg::CORE_WR_COUNT) begin
      rsp.read_data = wr_count;
    end else begin
      rsp.read_data = '0;
    end
  end

endmodule

`default_nettype wire

/* design/rdata_mux.sv */
//----------------------------------------------------------------------
// Response mux.
// Picks the response of the selected target and registers read
// data and ready towards the bus master.
//----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module rdata_mux (
  input  logic               clk,
  input  logic               reset_n,
  input  soc_pkg::target_e   target,
  input  soc_pkg::core_sel_t core_sel,
  input  soc_pkg::core_rsp_t sys_rsp,
  input  soc_pkg::core_rsp_t ram_rsp,
  input  soc_pkg::core_rsp_t core_rsp [soc_pkg::NUM_CORES],
  output logic               bus_ready,
  output soc_pkg::word_t     bus_rdata
);

  soc_pkg::core_rsp_t muxed_rsp;

  always_comb begin
    case (target)
      soc_pkg::RAM:  muxed_rsp = ram_rsp;
      soc_pkg::SYS:  muxed_rsp = sys_rsp;
      soc_pkg::CORE: muxed_rsp = core_rsp[core_sel];
      // Forced trap answers at once
      soc_pkg::TRAP: begin
        muxed_rsp.read_data = soc_pkg::ILLEGAL_INSTRUCTION;
        muxed_rsp.ready     = 1'b1;
      end
      default: begin
        muxed_rsp.read_data = '0;
        muxed_rsp.ready     = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      bus_ready <= 1'b0;
      bus_rdata <= '0;
    end else begin
      bus_ready <= muxed_rsp.ready;
      bus_rdata <= muxed_rsp.read_data;
    end
  end

endmodule

`default_nettype wire

/* design/app_subsystem.sv */
//----------------------------------------------------------------------
// Application subsystem top level.
// Decoder, system control, scrambled RAM, MMIO register cores
// and the response mux.
//----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module app_subsystem (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              bus_valid,
  input  soc_pkg::bus_req_t bus_req,
  output logic              bus_ready,
  output soc_pkg::word_t    bus_rdata
);

  soc_pkg::core_req_t sys_req;
  soc_pkg::core_rsp_t sys_rsp;
  logic               app_mode;
  soc_pkg::word_t     scramble_key;
  soc_pkg::word_t     aslr_mask;

  logic               ram_cs;
  soc_pkg::strb_t     ram_we;
  soc_pkg::ram_addr_t ram_addr;
  soc_pkg::word_t     ram_wdata;
  soc_pkg::core_rsp_t ram_rsp;

  soc_pkg::core_req_t core_req [soc_pkg::NUM_CORES];
  soc_pkg::core_rsp_t core_rsp [soc_pkg::NUM_CORES];
  soc_pkg::target_e   target;
  soc_pkg::core_sel_t core_sel;

  mem_decoder decoder_i (
    .clk(clk), .reset_n(reset_n),
    .bus_valid(bus_valid), .bus_req(bus_req), .bus_ready(bus_ready),
    .app_mode(app_mode), .sys_req(sys_req),
    .ram_cs(ram_cs), .ram_we(ram_we), .ram_addr(ram_addr), .ram_wdata(ram_wdata),
    .core_req(core_req), .target(target), .core_sel(core_sel)
  );

  sys_ctrl sys_ctrl_i (
    .clk(clk), .reset_n(reset_n), .req(sys_req), .rsp(sys_rsp),
    .app_mode(app_mode), .scramble_key(scramble_key), .aslr_mask(aslr_mask)
  );

  scramble_ram ram_i (
    .clk(clk), .reset_n(reset_n),
    .cs(ram_cs), .we(ram_we), .addr(ram_addr), .wdata(ram_wdata),
    .byte_addr(bus_req.addr[15 : 0]),
    .scramble_key(scramble_key), .aslr_mask(aslr_mask), .rsp(ram_rsp)
  );

  // MMIO cores at prefixes 0 and up
  for (genvar i = 0; i < soc_pkg::NUM_CORES; i++) begin : g_core
    reg_core core_i (
      .clk(clk), .reset_n(reset_n), .req(core_req[i]), .rsp(core_rsp[i])
    );
  end

  rdata_mux mux_i (
    .clk(clk), .reset_n(reset_n),
    .target(target), .core_sel(core_sel),
    .sys_rsp(sys_rsp), .ram_rsp(ram_rsp), .core_rsp(core_rsp),
    .bus_ready(bus_ready), .bus_rdata(bus_rdata)
  );

endmodule

`default_nettype wire

/* bench/app_subsystem_sva.sv */
//----------------------------------------------------------------------
// Bus handshake assertions, bound to the subsystem top level.
// Ready pulse width, reset value and one response per request.
//----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module app_subsystem_sva (
  input logic clk,
  input logic reset_n,
  input logic bus_valid,
  input logic bus_ready
);

  // Ready is a single-cycle pulse while a request is held
  ready_one_cycle: assert property (
    @(posedge clk) disable iff (!reset_n)
    (bus_valid && bus_ready) |=> !bus_ready
  ) else $error("bus_ready high for two cycles with bus_valid held");

  // Synchronous reset clears ready
  ready_low_after_reset: assert property (
    @(posedge clk) !reset_n |=> !bus_ready
  ) else $error("bus_ready not cleared by reset");

  // Each response answers a pending request
  response_has_request: assert property (
    @(posedge clk) disable iff (!reset_n)
    $rose(bus_ready) |-> $past(bus_valid)
  ) else $error("bus_ready rose with no request pending");

endmodule

`default_nettype wire

/* bench/tb_app_subsystem.sv */
//----------------------------------------------------------------------
// Testbench for the application subsystem.
// Bus master tasks, reference model of the sys registers, MMIO cores
// and scrambled RAM, a response compare process and directed plus
// random tests.
//----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_app_subsystem;

  localparam int TIMEOUT_CYCLES = 50;

  typedef struct packed {
    logic           check;
    soc_pkg::word_t data;
  } expect_t;

  logic              clk;
  logic              reset_n;
  logic              bus_valid;
  soc_pkg::bus_req_t bus_req;
  logic              bus_ready;
  soc_pkg::word_t    bus_rdata;

  // Reference model with the RAM kept as scrambled physical words
  soc_pkg::word_t model_ram [256];
  soc_pkg::word_t model_core [soc_pkg::NUM_CORES][5];
  soc_pkg::word_t model_key;
  soc_pkg::word_t model_mask;
  logic           model_app;
  expect_t        expected_q [$];

  app_subsystem dut_i (
    .clk(clk), .reset_n(reset_n), .bus_valid(bus_valid), .bus_req(bus_req),
    .bus_ready(bus_ready), .bus_rdata(bus_rdata)
  );

  bind app_subsystem app_subsystem_sva sva_i (
    .clk(clk), .reset_n(reset_n), .bus_valid(bus_valid), .bus_ready(bus_ready)
  );

  always #5 clk = ~clk;

  function automatic soc_pkg::addr_t mmio_addr(input int prefix, input int index);
    return {soc_pkg::AREA_MMIO, 6'(prefix), 14'h0, 8'(index), 2'b00};
  endfunction

  // Random upper address bits only feed the whitening
  function automatic soc_pkg::addr_t ram_addr(input int index);
    return {soc_pkg::AREA_RAM, 14'h0, 6'($urandom), 8'(index), 2'b00};
  endfunction

  function automatic soc_pkg::word_t whiten(input soc_pkg::word_t data,
                                            input soc_pkg::addr_t addr);
    return data ^ model_key ^ {2{addr[15 : 0]}};
  endfunction

  //--------------------------------------------------------------------
  // Reference model
  //--------------------------------------------------------------------
  function automatic soc_pkg::word_t expected_read(input soc_pkg::bus_req_t req);
    int index;
    int prefix;
    index  = int'(req.addr[9 : 2]);
    prefix = int'(req.addr[29 : 24]);
    if (req.addr[31 : 30] == soc_pkg::AREA_RAM) begin
      return whiten(model_ram[index ^ int'(model_mask[7 : 0])], req.addr);
    end
    if (req.addr[31 : 30] != soc_pkg::AREA_MMIO) begin
      return '0;
    end
    if (model_app && req.instr) begin
      return soc_pkg::ILLEGAL_INSTRUCTION;
    end
    if (prefix == int'(soc_pkg::SYS_CTRL_PREFIX)) begin
      case (index)
        0:       return {31'h0, model_app};
        1:       return model_key;
        2:       return model_mask;
        default: return '0;
      endcase
    end
    if (prefix < soc_pkg::NUM_CORES && index <= 4) begin
      return model_core[prefix][index];
    end
    return '0;
  endfunction

  function automatic void model_write(input soc_pkg::bus_req_t req);
    int             index;
    int             prefix;
    soc_pkg::word_t stored;
    index  = int'(req.addr[9 : 2]);
    prefix = int'(req.addr[29 : 24]);
    stored = whiten(req.wdata, req.addr);
    if (req.addr[31 : 30] == soc_pkg::AREA_RAM) begin
      for (int b = 0; b < 4; b++) begin
        if (req.wstrb[b]) begin
          model_ram[index ^ int'(model_mask[7 : 0])][8*b +: 8] = stored[8*b +: 8];
        end
      end
    end else if (req.addr[31 : 30] == soc_pkg::AREA_MMIO && !(model_app && req.instr)) begin
      if (prefix == int'(soc_pkg::SYS_CTRL_PREFIX)) begin
        if (index == 0) begin
          model_app = 1'b1;
        end else if (index == 1 && !model_app) begin
          model_key = req.wdata;
        end else if (index == 2 && !model_app) begin
          model_mask = req.wdata;
        end
      end else if (prefix < soc_pkg::NUM_CORES) begin
        if (index < 4) begin
          model_core[prefix][index] = req.wdata;
          model_core[prefix][4]++;
        end else if (index == 4) begin
          model_core[prefix][4] = '0;
        end
      end
    end
  endfunction

  //--------------------------------------------------------------------
  // Checks and bus master
  //--------------------------------------------------------------------
  task automatic check_value(input string name, input soc_pkg::word_t got,
                             input soc_pkg::word_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
      $display("Test FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic wait_ready(input logic level, output int cycles);
    cycles = 0;
    while (bus_ready !== level) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        $display("Timeout: bus_ready did not become %b in %0d cycles", level, TIMEOUT_CYCLES);
        $display("Test FAILED");
        $fatal(1, "handshake timeout");
      end
    end
  endtask

  // Holds the request until ready and checks the latency from acceptance
  task automatic access(input soc_pkg::bus_req_t req, input logic check_data,
                        output soc_pkg::word_t rdata);
    expect_t entry;
    int      cycles;
    entry.check = check_data;
    entry.data  = expected_read(req);
    expected_q.push_back(entry);
    bus_valid = 1'b1;
    bus_req   = req;
    wait_ready(1'b0, cycles);
    wait_ready(1'b1, cycles);
    rdata = bus_rdata;
    check_value("bus_ready latency", 32'(cycles),
                (req.addr[31 : 30] == soc_pkg::AREA_RAM) ? 32'd2 : 32'd1);
    if (|req.wstrb) begin
      model_write(req);
    end
  endtask

  task automatic bus_write(input soc_pkg::addr_t addr, input soc_pkg::word_t data,
                           input soc_pkg::strb_t strb, input logic instr);
    soc_pkg::bus_req_t req;
    soc_pkg::word_t    rdata;
    req.addr  = addr;
    req.wdata = data;
    req.wstrb = strb;
    req.instr = instr;
    access(req, 1'b0, rdata);
  endtask

  task automatic bus_read(input soc_pkg::addr_t addr, input logic instr,
                          output soc_pkg::word_t rdata);
    soc_pkg::bus_req_t req;
    req.addr  = addr;
    req.wdata = $urandom;
    req.wstrb = '0;
    req.instr = instr;
    access(req, 1'b1, rdata);
  endtask

  // Pairs each response with the oldest outstanding request
  always @(negedge clk) begin
    expect_t entry;
    if (reset_n && bus_ready) begin
      if (expected_q.size() == 0) begin
        $display("A response came with no request outstanding");
        $display("Test FAILED");
        $fatal(1, "unexpected response");
      end else begin
        entry = expected_q.pop_front();
        if (entry.check) begin
          check_value("bus_rdata", bus_rdata, entry.data);
        end
      end
    end
  end

  //--------------------------------------------------------------------
  // Test sequence
  //--------------------------------------------------------------------
  initial begin
    soc_pkg::word_t data;
    soc_pkg::word_t old_key;
    soc_pkg::word_t mask;
    soc_pkg::word_t got;
    soc_pkg::addr_t addr;
    soc_pkg::addr_t other_addr;
    int             cycles;
    void'($urandom(62044));
    clk         = 1'b0;
    reset_n     = 1'b0;
    bus_valid   = 1'b0;
    bus_req     = '0;
    model_key   = '0;
    model_mask  = '0;
    model_app   = 1'b0;
    for (int c = 0; c < soc_pkg::NUM_CORES; c++) begin
      for (int r = 0; r < 5; r++) begin
        model_core[c][r] = '0;
      end
    end
    repeat (16) @(negedge clk);
    reset_n = 1'b1;

    // MMIO cores with scratch words, unknown indices and counter clear
    for (int c = 0; c < soc_pkg::NUM_CORES; c++) begin
      for (int w = 0; w < 4; w++) begin
        bus_write(mmio_addr(c, w), $urandom, 4'hf, 1'b0);
      end
    end
    bus_write(mmio_addr(2, 7), $urandom, 4'hf, 1'b0);
    bus_write(mmio_addr(1, 2), $urandom, 4'h2, 1'b0);
    for (int c = 0; c < soc_pkg::NUM_CORES; c++) begin
      for (int w = 0; w < 8; w++) begin
        bus_read(mmio_addr(c, w), w[0], got);
      end
    end
    bus_write(mmio_addr(2, 4), '0, 4'h1, 1'b0);
    for (int c = 0; c < soc_pkg::NUM_CORES; c++) begin
      bus_read(mmio_addr(c, 4), 1'b0, got);
    end

    // RAM fill and random traffic with byte strobes
    for (int i = 0; i < 256; i++) begin
      bus_write(ram_addr(i), $urandom, 4'hf, 1'b0);
    end
    repeat (300) begin
      addr = ram_addr($urandom_range(0, 255));
      if ($urandom_range(0, 1) == 1) begin
        bus_write(addr, $urandom, 4'($urandom), 1'b0);
      end else begin
        bus_read(addr, 1'b0, got);
      end
    end

    // An old word reads back through the old and the new key
    repeat (2) begin
      addr = ram_addr($urandom_range(0, 255));
      data = $urandom;
      bus_write(addr, data, 4'hf, 1'b0);
      old_key = model_key;
      bus_write(mmio_addr(soc_pkg::SYS_CTRL_PREFIX, 1), $urandom, 4'hf, 1'b0);
      bus_read(addr, 1'b0, got);
      check_value("rekeyed word", got, data ^ old_key ^ model_key);
    end

    // ASLR remap
    mask = 32'($urandom_range(1, 255));
    bus_write(mmio_addr(soc_pkg::SYS_CTRL_PREFIX, 2), mask, 4'hf, 1'b0);
    repeat (64) begin
      bus_read(ram_addr($urandom_range(0, 255)), 1'b0, got);
    end
    addr = ram_addr(17);
    data = $urandom;
    bus_write(addr, data, 4'hf, 1'b0);
    bus_write(mmio_addr(soc_pkg::SYS_CTRL_PREFIX, 2), '0, 4'hf, 1'b0);
    other_addr = ram_addr(17 ^ int'(mask[7 : 0]));
    bus_read(other_addr, 1'b0, got);
    check_value("remapped word", got,
                data ^ {2{addr[15 : 0]}} ^ {2{other_addr[15 : 0]}});
    bus_write(mmio_addr(soc_pkg::SYS_CTRL_PREFIX, 2), 32'($urandom_range(1, 255)),
              4'hf, 1'b0);
    repeat (64) begin
      bus_read(ram_addr($urandom_range(0, 255)), 1'b0, got);
    end

    // Application mode locks key and mask
    old_key = model_key;
    bus_write(mmio_addr(soc_pkg::SYS_CTRL_PREFIX, 0), $urandom, 4'h8, 1'b0);
    bus_write(mmio_addr(soc_pkg::SYS_CTRL_PREFIX, 1), ~old_key, 4'hf, 1'b0);
    bus_write(mmio_addr(soc_pkg::SYS_CTRL_PREFIX, 2), $urandom, 4'hf, 1'b0);
    bus_read(mmio_addr(soc_pkg::SYS_CTRL_PREFIX, 0), 1'b0, got);
    bus_read(mmio_addr(soc_pkg::SYS_CTRL_PREFIX, 1), 1'b0, got);
    check_value("locked scramble key", got, old_key);
    bus_read(mmio_addr(soc_pkg::SYS_CTRL_PREFIX, 2), 1'b0, got);

    // Trap on MMIO fetch plus reserved areas and unused prefixes
    bus_read(mmio_addr(0, 0), 1'b1, got);
    bus_read(mmio_addr(soc_pkg::SYS_CTRL_PREFIX, 1), 1'b1, got);
    bus_write(mmio_addr(1, 0), $urandom, 4'hf, 1'b1);
    bus_read(mmio_addr(1, 0), 1'b0, got);
    bus_read(mmio_addr(1, 4), 1'b0, got);
    bus_read(ram_addr(3), 1'b1, got);
    bus_write({2'b00, 30'($urandom)}, $urandom, 4'hf, 1'b0);
    bus_read({2'b00, 30'($urandom)}, 1'b0, got);
    bus_read({2'b10, 30'($urandom)}, 1'b0, got);
    bus_read(mmio_addr(5, 0), 1'b0, got);
    bus_read(mmio_addr(6'h3e, 1), 1'b0, got);

    bus_valid = 1'b0;
    wait_ready(1'b0, cycles);
    @(negedge clk);
    if (expected_q.size() != 0) begin
      $display("%0d requests never got a response", expected_q.size());
      $display("Test FAILED");
      $fatal(1, "missing response");
    end else begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* tb.f */
design/soc_pkg.sv
design/mem_decoder.sv
design/sys_ctrl.sv
design/scramble_ram.sv
design/reg_core.sv
design/rdata_mux.sv
design/app_subsystem.sv
bench/app_subsystem_sva.sv
bench/tb_app_subsystem.sv

/* Makefile */
# Verilator build and run of the application subsystem testbench

VERILATOR  ?= verilator
TOP        ?= tb_app_subsystem
FILELIST   ?= tb.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= Test FAILED
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails on a nonzero exit status or on the fail message in the log
run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
